// ==== hw/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath
`define MIPS_XLEN 32      // data and address width
`define MIPS_REG_AW 5     // 32 architectural registers

// memories
`define MIPS_IMEM_DEPTH 64   // instruction words
`define MIPS_DMEM_DEPTH 64   // data words
`define MIPS_MEM_AW 6        // word index into either memory

// debug port address map
`define MIPS_APB_AW 12        // byte address width on apb
`define MIPS_APB_DMEM_BIT 11  // set selects data memory, clear selects imem

`endif

// ==== hw/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	// primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'b000000,
		op_beq   = 6'b000100,
		op_addi  = 6'b001000,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011
	} opcode_e;

	// function field of r-type, inst[5:0]
	typedef enum logic [5:0] {
		fn_add = 6'd32,
		fn_sub = 6'd34,
		fn_and = 6'd36,
		fn_or  = 6'd37,
		fn_nor = 6'd39,
		fn_slt = 6'd42
	} funct_e;

	// coarse alu request from decode
	typedef enum logic [1:0] {
		alu_cls_mem_add    = 2'd0, // lw, sw, addi
		alu_cls_branch_sub = 2'd1, // beq compare
		alu_cls_rtype      = 2'd2  // look at funct
	} alu_class_e;

	// alu operation select
	typedef enum logic [3:0] {
		alu_and  = 4'd0,
		alu_or   = 4'd1,
		alu_add  = 4'd2,
		alu_sub  = 4'd6,
		alu_slt  = 4'd7,
		alu_nor  = 4'd12,
		alu_none = 4'd15 // result forced to zero
	} alu_sel_e;

endpackage

`default_nettype wire

// ==== hw/mips_bus_pkg.sv ====
`default_nettype none

package mips_bus_pkg;

	// phase of the current apb cycle as seen by the slave
	typedef enum logic [1:0] {
		apb_idle   = 2'd0,
		apb_setup  = 2'd1,
		apb_access = 2'd2
	} apb_phase_e;

	// who drives the data memory port this cycle
	typedef enum logic {
		owner_core  = 1'b0,
		owner_debug = 1'b1
	} dmem_owner_e;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module fetch_stage
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    stall,
	input  logic                    branch_taken,  // from mem stage
	input  logic [`MIPS_XLEN-1:0]   branch_target,
	input  logic                    imem_we,       // debug port write
	input  logic [`MIPS_MEM_AW-1:0] imem_waddr,
	input  logic [`MIPS_XLEN-1:0]   imem_wdata,
	output logic [`MIPS_XLEN-1:0]   d_inst,
	output logic [`MIPS_XLEN-1:0]   d_pc_next
);

	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] pc_next;
	logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_DEPTH]; // loaded over apb

	assign pc_plus4 = pc + `MIPS_XLEN'(4);

	// branch wins over stall so a resolved beq is never lost
	always_comb
	begin
		if (branch_taken)
			pc_next = branch_target;
		else if (stall)
			pc_next = pc; // hold
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			pc <= '0;
		else
			pc <= pc_next;
	end

	always_ff @(posedge clk)
	begin
		if (imem_we)
			imem[imem_waddr] <= imem_wdata;
	end

	// if/id register
	always_ff @(posedge clk)
	begin
		if (!rst)
			d_inst <= '0;
		else
			d_inst <= stall ? '0 : imem[pc[`MIPS_MEM_AW+1:2]]; // nop under stall
	end

	always_ff @(posedge clk)
	begin
		d_pc_next <= pc_plus4; // payload, no reset
	end

	// a stalled fetch always shows up in decode as a nop
	assert property (@(posedge clk) disable iff (!rst) stall |=> d_inst == '0);

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module decode_stage import mips_isa_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MIPS_XLEN-1:0]   d_inst,
	input  logic [`MIPS_XLEN-1:0]   d_pc_next,
	input  logic                    w_regwrite,  // write-back port
	input  logic [`MIPS_REG_AW-1:0] w_dest,
	input  logic [`MIPS_XLEN-1:0]   w_data,
	output logic [`MIPS_XLEN-1:0]   e_pc_next,
	output logic [`MIPS_XLEN-1:0]   e_rs_val,
	output logic [`MIPS_XLEN-1:0]   e_rt_val,
	output logic [`MIPS_XLEN-1:0]   e_imm,
	output logic [`MIPS_REG_AW-1:0] e_rt,
	output logic [`MIPS_REG_AW-1:0] e_rd,
	output funct_e                  e_funct,
	output alu_class_e              e_alu_class,
	output logic                    e_alu_src_imm,
	output logic                    e_dest_rd,
	output logic                    e_regwrite,
	output logic                    e_memread,
	output logic                    e_memwrite,
	output logic                    e_memtoreg,
	output logic                    e_branch
);

	opcode_e                 opcode;
	logic [`MIPS_REG_AW-1:0] rs;
	logic [`MIPS_REG_AW-1:0] rt;
	logic [`MIPS_REG_AW-1:0] rd;
	logic [`MIPS_REG_AW-1:0] dest;
	logic [`MIPS_XLEN-1:0]   imm_ext;
	alu_class_e              alu_class;
	logic                    alu_src_imm;
	logic                    dest_rd;
	logic                    regwrite;
	logic                    memread;
	logic                    memwrite;
	logic                    memtoreg;
	logic                    branch;
	logic [`MIPS_XLEN-1:0]   regs [2**`MIPS_REG_AW]; // architectural registers

	// field split
	assign opcode  = opcode_e'(d_inst[31:26]);
	assign rs      = d_inst[25:21];
	assign rt      = d_inst[20:16];
	assign rd      = d_inst[15:11];
	assign imm_ext = {{(`MIPS_XLEN-16){d_inst[15]}}, d_inst[15:0]}; // true sign fill

	// main control, unknown opcodes decode as nop
	always_comb
	begin
		alu_class   = alu_cls_mem_add;
		alu_src_imm = 1'b0;
		dest_rd     = 1'b0;
		regwrite    = 1'b0;
		memread     = 1'b0;
		memwrite    = 1'b0;
		memtoreg    = 1'b0;
		branch      = 1'b0;
		case (opcode)
			op_rtype:
			begin
				alu_class = alu_cls_rtype;
				dest_rd   = 1'b1; // rd is the target
				regwrite  = 1'b1;
			end
			op_beq:
			begin
				alu_class = alu_cls_branch_sub; // zero flag does the compare
				branch    = 1'b1;
			end
			op_addi:
			begin
				alu_src_imm = 1'b1;
				regwrite    = 1'b1;
			end
			op_lw:
			begin
				alu_src_imm = 1'b1;
				regwrite    = 1'b1;
				memread     = 1'b1;
				memtoreg    = 1'b1;
			end
			op_sw:
			begin
				alu_src_imm = 1'b1;
				memwrite    = 1'b1;
			end
			default:
			begin
				branch = 1'b0; // nop
			end
		endcase
	end

	assign dest = dest_rd ? rd : rt;

	// r0 reads zero, a same-cycle write is passed straight through
	function automatic logic [`MIPS_XLEN-1:0] rf_read(input logic [`MIPS_REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (w_regwrite && w_dest == addr)
			return w_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (w_regwrite && w_dest != '0)
			regs[w_dest] <= w_data;
	end

	// id/ex control
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			e_regwrite <= 1'b0;
			e_memread  <= 1'b0;
			e_memwrite <= 1'b0;
			e_branch   <= 1'b0;
		end
		else
		begin
			e_regwrite <= regwrite && dest != '0; // r0 never written
			e_memread  <= memread;
			e_memwrite <= memwrite;
			e_branch   <= branch;
		end
	end

	// id/ex payload
	always_ff @(posedge clk)
	begin
		e_pc_next     <= d_pc_next;
		e_rs_val      <= rf_read(rs);
		e_rt_val      <= rf_read(rt);
		e_imm         <= imm_ext;
		e_rt          <= rt;
		e_rd          <= rd;
		e_funct       <= funct_e'(d_inst[5:0]);
		e_alu_class   <= alu_class;
		e_alu_src_imm <= alu_src_imm;
		e_dest_rd     <= dest_rd;
		e_memtoreg    <= memtoreg;
	end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module execute_stage import mips_isa_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MIPS_XLEN-1:0]   e_pc_next,
	input  logic [`MIPS_XLEN-1:0]   e_rs_val,
	input  logic [`MIPS_XLEN-1:0]   e_rt_val,
	input  logic [`MIPS_XLEN-1:0]   e_imm,
	input  logic [`MIPS_REG_AW-1:0] e_rt,
	input  logic [`MIPS_REG_AW-1:0] e_rd,
	input  funct_e                  e_funct,
	input  alu_class_e              e_alu_class,
	input  logic                    e_alu_src_imm,
	input  logic                    e_dest_rd,
	input  logic                    e_regwrite,
	input  logic                    e_memread,
	input  logic                    e_memwrite,
	input  logic                    e_memtoreg,
	input  logic                    e_branch,
	output logic [`MIPS_XLEN-1:0]   m_alu_res,
	output logic [`MIPS_XLEN-1:0]   m_rt_val,
	output logic [`MIPS_XLEN-1:0]   m_branch_target,
	output logic                    m_zero,
	output logic [`MIPS_REG_AW-1:0] m_dest,
	output logic                    m_regwrite,
	output logic                    m_memread,
	output logic                    m_memwrite,
	output logic                    m_memtoreg,
	output logic                    m_branch
);

	alu_sel_e              alu_sel;
	logic [`MIPS_XLEN-1:0] alu_b;
	logic [`MIPS_XLEN-1:0] alu_res;

	// alu control
	always_comb
	begin
		case (e_alu_class)
			alu_cls_mem_add:    alu_sel = alu_add;
			alu_cls_branch_sub: alu_sel = alu_sub;
			default:
			begin
				case (e_funct)
					fn_add:  alu_sel = alu_add;
					fn_sub:  alu_sel = alu_sub;
					fn_and:  alu_sel = alu_and;
					fn_or:   alu_sel = alu_or;
					fn_nor:  alu_sel = alu_nor;
					fn_slt:  alu_sel = alu_slt;
					default: alu_sel = alu_none; // also the all-zero nop
				endcase
			end
		endcase
	end

	assign alu_b = e_alu_src_imm ? e_imm : e_rt_val;

	always_comb
	begin
		case (alu_sel)
			alu_and: alu_res = e_rs_val & alu_b;
			alu_or:  alu_res = e_rs_val | alu_b;
			alu_add: alu_res = e_rs_val + alu_b;
			alu_sub: alu_res = e_rs_val - alu_b;
			alu_slt: alu_res = ($signed(e_rs_val) < $signed(alu_b)) ? `MIPS_XLEN'(1) : '0;
			alu_nor: alu_res = ~(e_rs_val | alu_b);
			default: alu_res = '0;
		endcase
	end

	// ex/mem control
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			m_regwrite <= 1'b0;
			m_memread  <= 1'b0;
			m_memwrite <= 1'b0;
			m_branch   <= 1'b0;
		end
		else
		begin
			m_regwrite <= e_regwrite;
			m_memread  <= e_memread;
			m_memwrite <= e_memwrite;
			m_branch   <= e_branch;
		end
	end

	// ex/mem payload
	always_ff @(posedge clk)
	begin
		m_alu_res       <= alu_res;
		m_zero          <= alu_res == '0;
		m_rt_val        <= e_rt_val;                 // store data
		m_branch_target <= e_pc_next + (e_imm << 2); // word offset from pc+4
		m_dest          <= e_dest_rd ? e_rd : e_rt;
		m_memtoreg      <= e_memtoreg;
	end

	// only a bad funct can reach the none select
	assert property (@(posedge clk) disable iff (!rst)
		alu_sel == alu_none |-> e_alu_class == alu_cls_rtype);

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module mem_stage
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MIPS_XLEN-1:0]   m_alu_res,
	input  logic [`MIPS_XLEN-1:0]   m_rt_val,
	input  logic [`MIPS_XLEN-1:0]   m_branch_target,
	input  logic                    m_zero,
	input  logic [`MIPS_REG_AW-1:0] m_dest,
	input  logic                    m_regwrite,
	input  logic                    m_memread,
	input  logic                    m_memwrite,
	input  logic                    m_memtoreg,
	input  logic                    m_branch,
	input  logic [`MIPS_XLEN-1:0]   core_rdata,    // combinational load data
	output logic                    core_req,
	output logic                    core_we,
	output logic [`MIPS_MEM_AW-1:0] core_addr,
	output logic [`MIPS_XLEN-1:0]   core_wdata,
	output logic                    branch_taken,  // to fetch
	output logic [`MIPS_XLEN-1:0]   branch_target,
	output logic                    w_regwrite,
	output logic [`MIPS_REG_AW-1:0] w_dest,
	output logic [`MIPS_XLEN-1:0]   w_data
);

	// data memory request, always granted
	assign core_req   = m_memread || m_memwrite;
	assign core_we    = m_memwrite;
	assign core_addr  = m_alu_res[`MIPS_MEM_AW+1:2]; // word index
	assign core_wdata = m_rt_val;

	// beq taken when rs - rt was zero
	assign branch_taken  = m_branch && m_zero;
	assign branch_target = m_branch_target;

	// mem/wb
	always_ff @(posedge clk)
	begin
		if (!rst)
			w_regwrite <= 1'b0;
		else
			w_regwrite <= m_regwrite;
	end

	always_ff @(posedge clk)
	begin
		w_dest <= m_dest;
		w_data <= m_memtoreg ? core_rdata : m_alu_res; // load or alu
	end

endmodule

`default_nettype wire

// ==== hw/dmem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module dmem_arbiter import mips_bus_pkg::*;
(
	input  logic                    clk,
	input  logic                    core_req,
	input  logic                    core_we,
	input  logic [`MIPS_MEM_AW-1:0] core_addr,
	input  logic [`MIPS_XLEN-1:0]   core_wdata,
	input  logic                    dbg_req,
	input  logic                    dbg_we,
	input  logic [`MIPS_MEM_AW-1:0] dbg_addr,
	input  logic [`MIPS_XLEN-1:0]   dbg_wdata,
	output logic [`MIPS_XLEN-1:0]   core_rdata,
	output logic                    dbg_grant,
	output logic [`MIPS_XLEN-1:0]   dbg_rdata
);

	dmem_owner_e             owner;
	logic [`MIPS_MEM_AW-1:0] addr;
	logic                    wr_en;
	logic [`MIPS_XLEN-1:0]   wr_data;
	logic [`MIPS_XLEN-1:0]   rdata;
	logic [`MIPS_XLEN-1:0]   dmem [`MIPS_DMEM_DEPTH]; // single ported

	// core first, debug only gets idle cycles
	assign owner     = core_req ? owner_core : owner_debug;
	assign dbg_grant = dbg_req && owner == owner_debug;

	// port mux
	always_comb
	begin
		if (owner == owner_core)
		begin
			addr    = core_addr;
			wr_en   = core_we;
			wr_data = core_wdata;
		end
		else
		begin
			addr    = dbg_addr;
			wr_en   = dbg_grant && dbg_we;
			wr_data = dbg_wdata;
		end
	end

	// read is asynchronous, shared by both sides
	assign rdata      = dmem[addr];
	assign core_rdata = rdata;
	assign dbg_rdata  = rdata;

	always_ff @(posedge clk)
	begin
		if (wr_en)
			dmem[addr] <= wr_data;
	end

	// a debug store must never land on top of a core access
	assert property (@(posedge clk)
		core_req |-> !dbg_grant && wr_en == core_we && addr == core_addr);

endmodule

`default_nettype wire

// ==== hw/apb_debug_port.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module apb_debug_port import mips_bus_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MIPS_APB_AW-1:0] paddr,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`MIPS_XLEN-1:0]   pwdata,
	input  logic                    dbg_grant,   // from arbiter
	input  logic [`MIPS_XLEN-1:0]   dbg_rdata,
	output logic [`MIPS_XLEN-1:0]   prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    imem_we,
	output logic [`MIPS_MEM_AW-1:0] imem_waddr,
	output logic [`MIPS_XLEN-1:0]   imem_wdata,
	output logic                    dbg_req,
	output logic                    dbg_we,
	output logic [`MIPS_MEM_AW-1:0] dbg_addr,
	output logic [`MIPS_XLEN-1:0]   dbg_wdata
);

	apb_phase_e              phase_q;  // idle or access
	apb_phase_e              phase;    // this cycle
	logic                    sel_dmem;
	logic                    access;
	logic [`MIPS_MEM_AW-1:0] word_addr;

	always_comb
	begin
		if (!psel)
			phase = apb_idle;
		else if (phase_q == apb_access && penable)
			phase = apb_access;
		else
			phase = apb_setup; // first cycle of a transfer
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			phase_q <= apb_idle;
		else if (phase == apb_setup || (phase == apb_access && !pready))
			phase_q <= apb_access; // enter or keep waiting
		else
			phase_q <= apb_idle;
	end

	assign access    = phase == apb_access;
	assign sel_dmem  = paddr[`MIPS_APB_DMEM_BIT];
	assign word_addr = paddr[`MIPS_MEM_AW+1:2];

	// instruction memory side, write only
	assign imem_we    = access && !sel_dmem && pwrite;
	assign imem_waddr = word_addr;
	assign imem_wdata = pwdata;

	// data memory side, waits on the arbiter
	assign dbg_req   = access && sel_dmem;
	assign dbg_we    = pwrite;
	assign dbg_addr  = word_addr;
	assign dbg_wdata = pwdata;

	assign pready  = access && (!sel_dmem || dbg_grant);
	assign pslverr = access && !sel_dmem && !pwrite; // imem is not readable
	assign prdata  = dbg_req ? dbg_rdata : '0;

	// completion only after a setup cycle and only in access
	assert property (@(posedge clk) disable iff (!rst)
		pready |-> phase == apb_access && $past(psel));

endmodule

`default_nettype wire

// ==== hw/mips_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module mips_core_top import mips_isa_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    stall,
	input  logic [`MIPS_APB_AW-1:0] paddr,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`MIPS_XLEN-1:0]   pwdata,
	output logic [`MIPS_XLEN-1:0]   prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    wb_valid,
	output logic [`MIPS_REG_AW-1:0] wb_reg,
	output logic [`MIPS_XLEN-1:0]   wb_data
);

	logic                    imem_we;
	logic [`MIPS_MEM_AW-1:0] imem_waddr;
	logic [`MIPS_XLEN-1:0]   imem_wdata;
	logic                    branch_taken;
	logic [`MIPS_XLEN-1:0]   branch_target;
	logic [`MIPS_XLEN-1:0]   d_inst;
	logic [`MIPS_XLEN-1:0]   d_pc_next;
	logic [`MIPS_XLEN-1:0]   e_pc_next;
	logic [`MIPS_XLEN-1:0]   e_rs_val;
	logic [`MIPS_XLEN-1:0]   e_rt_val;
	logic [`MIPS_XLEN-1:0]   e_imm;
	logic [`MIPS_REG_AW-1:0] e_rt;
	logic [`MIPS_REG_AW-1:0] e_rd;
	funct_e                  e_funct;
	alu_class_e              e_alu_class;
	logic                    e_alu_src_imm;
	logic                    e_dest_rd;
	logic                    e_regwrite;
	logic                    e_memread;
	logic                    e_memwrite;
	logic                    e_memtoreg;
	logic                    e_branch;
	logic [`MIPS_XLEN-1:0]   m_alu_res;
	logic [`MIPS_XLEN-1:0]   m_rt_val;
	logic [`MIPS_XLEN-1:0]   m_branch_target;
	logic                    m_zero;
	logic [`MIPS_REG_AW-1:0] m_dest;
	logic                    m_regwrite;
	logic                    m_memread;
	logic                    m_memwrite;
	logic                    m_memtoreg;
	logic                    m_branch;
	logic                    core_req;
	logic                    core_we;
	logic [`MIPS_MEM_AW-1:0] core_addr;
	logic [`MIPS_XLEN-1:0]   core_wdata;
	logic [`MIPS_XLEN-1:0]   core_rdata;
	logic                    dbg_req;
	logic                    dbg_we;
	logic [`MIPS_MEM_AW-1:0] dbg_addr;
	logic [`MIPS_XLEN-1:0]   dbg_wdata;
	logic                    dbg_grant;
	logic [`MIPS_XLEN-1:0]   dbg_rdata;
	logic                    w_regwrite;
	logic [`MIPS_REG_AW-1:0] w_dest;
	logic [`MIPS_XLEN-1:0]   w_data;

	// write-back port doubles as the observation port
	assign wb_valid = w_regwrite;
	assign wb_reg   = w_dest;
	assign wb_data  = w_data;

	fetch_stage u_fetch_stage (
		.clk, .rst, .stall, .branch_taken, .branch_target,
		.imem_we, .imem_waddr, .imem_wdata, .d_inst, .d_pc_next
	);

	decode_stage u_decode_stage (
		.clk, .rst, .d_inst, .d_pc_next, .w_regwrite, .w_dest, .w_data,
		.e_pc_next, .e_rs_val, .e_rt_val, .e_imm, .e_rt, .e_rd, .e_funct,
		.e_alu_class, .e_alu_src_imm, .e_dest_rd, .e_regwrite, .e_memread,
		.e_memwrite, .e_memtoreg, .e_branch
	);

	execute_stage u_execute_stage (
		.clk, .rst, .e_pc_next, .e_rs_val, .e_rt_val, .e_imm, .e_rt, .e_rd,
		.e_funct, .e_alu_class, .e_alu_src_imm, .e_dest_rd, .e_regwrite,
		.e_memread, .e_memwrite, .e_memtoreg, .e_branch,
		.m_alu_res, .m_rt_val, .m_branch_target, .m_zero, .m_dest,
		.m_regwrite, .m_memread, .m_memwrite, .m_memtoreg, .m_branch
	);

	mem_stage u_mem_stage (
		.clk, .rst, .m_alu_res, .m_rt_val, .m_branch_target, .m_zero, .m_dest,
		.m_regwrite, .m_memread, .m_memwrite, .m_memtoreg, .m_branch, .core_rdata,
		.core_req, .core_we, .core_addr, .core_wdata, .branch_taken,
		.branch_target, .w_regwrite, .w_dest, .w_data
	);

	dmem_arbiter u_dmem_arbiter (
		.clk, .core_req, .core_we, .core_addr, .core_wdata,
		.dbg_req, .dbg_we, .dbg_addr, .dbg_wdata,
		.core_rdata, .dbg_grant, .dbg_rdata
	);

	apb_debug_port u_apb_debug_port (
		.clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .dbg_grant, .dbg_rdata,
		.prdata, .pready, .pslverr, .imem_we, .imem_waddr, .imem_wdata,
		.dbg_req, .dbg_we, .dbg_addr, .dbg_wdata
	);

endmodule

`default_nettype wire

// ==== sim/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [`MIPS_XLEN-1:0]   model_regs [2**`MIPS_REG_AW]; // architectural registers
logic [`MIPS_XLEN-1:0]   model_dmem [`MIPS_DMEM_DEPTH];
logic [`MIPS_REG_AW-1:0] exp_reg [$];                 // expected write-back order
logic [`MIPS_XLEN-1:0]   exp_data [$];

function automatic logic [`MIPS_XLEN-1:0] sign_ext16(input logic [15:0] imm);
	return {{(`MIPS_XLEN-16){imm[15]}}, imm};
endfunction

function automatic logic [`MIPS_XLEN-1:0] alu_result(input funct_e fn,
	input logic [`MIPS_XLEN-1:0] a, input logic [`MIPS_XLEN-1:0] b);
	case (fn)
		fn_add: return a + b;
		fn_sub: return a - b;
		fn_and: return a & b;
		fn_or:  return a | b;
		fn_nor: return ~(a | b);
		fn_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		default: return '0; // all-zero nop lands here
	endcase
endfunction

// r0 stays zero and never shows up on write-back
function automatic void model_write(input logic [`MIPS_REG_AW-1:0] r,
	input logic [`MIPS_XLEN-1:0] v);
	if (r != '0)
	begin
		model_regs[r] = v;
		exp_reg.push_back(r);
		exp_data.push_back(v);
	end
endfunction

// one instruction per step, delay slots are nops so no pipeline detail is needed
task automatic model_run(output logic ended);
	logic [`MIPS_MEM_AW-1:0] pc;      // word index
	logic [`MIPS_MEM_AW-1:0] pc_next;
	logic [`MIPS_XLEN-1:0]   inst;
	logic [`MIPS_XLEN-1:0]   a;
	logic [`MIPS_XLEN-1:0]   b;
	logic [`MIPS_XLEN-1:0]   imm;
	logic [`MIPS_XLEN-1:0]   addr;
	int                      steps;
	pc = '0;
	steps = 0;
	ended = 1'b0;
	while (!ended && steps < 1000)
	begin
		inst = prog_words[pc];
		a = model_regs[inst[25:21]];
		b = model_regs[inst[20:16]];
		imm = sign_ext16(inst[15:0]);
		addr = a + imm;
		pc_next = pc + 6'd1;
		case (opcode_e'(inst[31:26]))
			op_rtype: model_write(inst[15:11], alu_result(funct_e'(inst[5:0]), a, b));
			op_addi:  model_write(inst[20:16], addr);
			op_lw:    model_write(inst[20:16], model_dmem[addr[`MIPS_MEM_AW+1:2]]);
			op_sw:    model_dmem[addr[`MIPS_MEM_AW+1:2]] = b;
			op_beq:
			begin
				if (a == b)
				begin
					pc_next = pc + 6'd1 + imm[`MIPS_MEM_AW-1:0]; // offset from pc+4
					ended = pc_next == pc;                      // self loop ends the program
				end
			end
			default: steps = steps; // unused opcode, acts as nop
		endcase
		pc = pc_next;
		steps++;
	end
endtask

`endif

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module tb_mips_core import mips_isa_pkg::*;
();

	localparam int NUM_PROGS    = 6;
	localparam int PROG_SLOTS   = `MIPS_IMEM_DEPTH / 4; // instruction plus three nops each
	localparam int APB_TIMEOUT  = 200;
	localparam int WB_TIMEOUT   = 3000;
	localparam int DRAIN_CYCLES = `MIPS_IMEM_DEPTH + 4; // one word per edge, then the pipe

	logic                    clk;
	logic                    rst;
	logic                    stall;
	logic [`MIPS_APB_AW-1:0] paddr;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [`MIPS_XLEN-1:0]   pwdata;
	logic [`MIPS_XLEN-1:0]   prdata;
	logic                    pready;
	logic                    pslverr;
	logic                    wb_valid;
	logic [`MIPS_REG_AW-1:0] wb_reg;
	logic [`MIPS_XLEN-1:0]   wb_data;
	logic [`MIPS_XLEN-1:0]   prog_words [`MIPS_IMEM_DEPTH]; // whole imem image
	logic [`MIPS_REG_AW-1:0] got_reg [$];                   // observed write-backs
	logic [`MIPS_XLEN-1:0]   got_data [$];
	logic                    running;
	int                      errors;
	int                      checks;

	`include "ref_model.svh"

	mips_core_top u_mips_core_top (
		.clk, .rst, .stall, .paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr, .wb_valid, .wb_reg, .wb_data
	);

	always #20 clk = ~clk; // 40 ns period

	// pre-edge values, every output comes from a flop or settles before the edge
	always @(posedge clk)
	begin
		if (rst && wb_valid)
		begin
			got_reg.push_back(wb_reg);
			got_data.push_back(wb_data);
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	// setup then access until pready, sampled at the edge closing each access cycle
	task automatic apb_transfer(input logic write, input logic [`MIPS_APB_AW-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int   waited;
		logic done;
		rdata = '0;
		err = 1'b0;
		waited = 0;
		done = 1'b0;
		@(posedge clk);
		paddr <= addr;
		pwrite <= write;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		while (!done && waited < APB_TIMEOUT)
		begin
			@(posedge clk);
			waited++;
			if (pready)
			begin
				done = 1'b1;
				rdata = prdata;
				err = pslverr;
			end
		end
		psel <= 1'b0;
		penable <= 1'b0;
		if (!done)
			note_failure($sformatf("APB transfer to address %h never completed", addr));
	endtask

	function automatic logic [`MIPS_APB_AW-1:0] dmem_addr(input logic [`MIPS_MEM_AW-1:0] idx);
		logic [`MIPS_APB_AW-1:0] addr;
		addr = '0;
		addr[`MIPS_APB_DMEM_BIT] = 1'b1;
		addr[`MIPS_MEM_AW+1:2] = idx;
		return addr;
	endfunction

	task automatic dmem_write(input logic [`MIPS_MEM_AW-1:0] idx, input logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		apb_transfer(1'b1, dmem_addr(idx), data, unused, err);
		if (err)
			note_failure($sformatf("data memory write to word %0d returned an error", idx));
	endtask

	task automatic dmem_read(input logic [`MIPS_MEM_AW-1:0] idx, output logic [31:0] data);
		logic err;
		apb_transfer(1'b0, dmem_addr(idx), '0, data, err);
		if (err)
			note_failure($sformatf("data memory read of word %0d returned an error", idx));
	endtask

	task automatic imem_write(input logic [`MIPS_MEM_AW-1:0] idx, input logic [31:0] data);
		logic [31:0]             unused;
		logic                    err;
		logic [`MIPS_APB_AW-1:0] addr;
		addr = '0;
		addr[`MIPS_MEM_AW+1:2] = idx; // dmem bit clear
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	function automatic logic [31:0] enc_rtype(input funct_e fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_itype(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic funct_e pick_funct();
		case ($urandom % 6)
			0: return fn_add;
			1: return fn_sub;
			2: return fn_and;
			3: return fn_or;
			4: return fn_nor;
			default: return fn_slt;
		endcase
	endfunction

	// r1..r4 plus some r0 targets, loads and stores in the low half of dmem
	task automatic build_program();
		int         i;
		int         k;
		int         kind;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		for (i = 0; i < `MIPS_IMEM_DEPTH; i++)
			prog_words[6'(i)] = '0;
		for (i = 0; i < 4; i++)
			prog_words[6'(4*i)] = enc_itype(op_addi, 5'd0, 5'(i + 1), 16'($urandom));
		for (i = 4; i < PROG_SLOTS - 1; i++)
		begin
			kind = $urandom % 10;
			rs = 5'($urandom % 5);
			rt = 5'($urandom % 5);
			rd = 5'($urandom % 5);
			if (kind < 4)
				prog_words[6'(4*i)] = enc_rtype(pick_funct(), rd, rs, rt);
			else if (kind < 6)
				prog_words[6'(4*i)] = enc_itype(op_addi, rs, rt, 16'($urandom));
			else if (kind == 6)
				prog_words[6'(4*i)] = enc_itype(op_lw, 5'd0, rt, 16'(4 * ($urandom % 32)));
			else if (kind == 7)
				prog_words[6'(4*i)] = enc_itype(op_sw, 5'd0, rt, 16'(4 * ($urandom % 32)));
			else
			begin
				k = 1 + $urandom % 3; // skip ahead by k slots when taken
				if (i + k > PROG_SLOTS - 1)
					k = PROG_SLOTS - 1 - i;
				if ($urandom % 2 == 0)
					rt = rs; // forces taken
				prog_words[6'(4*i)] = enc_itype(op_beq, rs, rt, 16'(4*k - 1));
			end
		end
		prog_words[6'(4*(PROG_SLOTS-1))] = enc_itype(op_beq, 5'd0, 5'd0, 16'hffff); // self loop
	endtask

	task automatic stall_pulses();
		while (running)
		begin
			@(posedge clk);
			stall <= ($urandom % 6 == 0);
		end
	endtask

	// upper half of dmem is never touched by programs
	task automatic background_reads();
		logic [`MIPS_MEM_AW-1:0] idx;
		logic [31:0]             v;
		int                      n;
		n = 0;
		while (running && n < 40)
		begin
			idx = 6'(32 + $urandom % 32);
			dmem_read(idx, v);
			check_value($sformatf("read of word %0d during run", idx), model_dmem[idx], v);
			n++;
		end
	endtask

	task automatic wait_writebacks(input int base);
		int waited;
		waited = 0;
		while (got_reg.size() - base < exp_reg.size() && waited < WB_TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (got_reg.size() - base < exp_reg.size())
			note_failure("timed out waiting for the expected write-back events");
		running = 1'b0;
	endtask

	initial
	begin
		int          p;
		int          i;
		int          base;
		logic [31:0] v;
		logic        err;
		logic        ended;
		void'($urandom(95849));
		errors = 0;
		checks = 0;
		running = 1'b0;
		clk = 1'b0;
		rst = 1'b0;
		stall = 1'b1; // core idle while memories load
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		for (i = 0; i < 2**`MIPS_REG_AW; i++)
			model_regs[5'(i)] = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		check_value("reset wb_valid", 32'd0, 32'(wb_valid));
		check_value("reset pready", 32'd0, 32'(pready));
		check_value("reset pslverr", 32'd0, 32'(pslverr));

		// debug port basics
		dmem_write(6'd5, 32'hc0de_5a5a);
		dmem_read(6'd5, v);
		check_value("apb data readback", 32'hc0de_5a5a, v);
		apb_transfer(1'b0, 12'h010, '0, v, err);
		check_value("apb imem read pslverr", 32'd1, 32'(err));

		for (i = 0; i < `MIPS_DMEM_DEPTH; i++)
		begin
			model_dmem[6'(i)] = $urandom;
			dmem_write(6'(i), model_dmem[6'(i)]);
		end

		for (p = 0; p < NUM_PROGS; p++)
		begin
			build_program();
			exp_reg.delete();
			exp_data.delete();
			model_run(ended);
			if (!ended)
				note_failure($sformatf("model of program %0d never reached its final loop", p));
			@(posedge clk);
			stall <= 1'b1;
			rst <= 1'b0; // pc back to zero
			repeat (3) @(posedge clk);
			rst <= 1'b1;
			for (i = 0; i < `MIPS_IMEM_DEPTH; i++)
				imem_write(6'(i), prog_words[6'(i)]);
			base = got_reg.size();
			running = 1'b1;
			fork
				wait_writebacks(base);
				stall_pulses();
				background_reads();
			join
			@(posedge clk);
			stall <= 1'b0;
			repeat (DRAIN_CYCLES) @(posedge clk); // trailing stores reach dmem
			check_value($sformatf("prog %0d write-back count", p),
				exp_reg.size(), got_reg.size() - base);
			for (i = 0; i < exp_reg.size() && base + i < got_reg.size(); i++)
			begin
				check_value($sformatf("prog %0d wb %0d reg", p, i),
					32'(exp_reg[i]), 32'(got_reg[base + i]));
				check_value($sformatf("prog %0d wb %0d data", p, i),
					exp_data[i], got_data[base + i]);
			end
			for (i = 0; i < `MIPS_DMEM_DEPTH; i++)
			begin
				dmem_read(6'(i), v);
				check_value($sformatf("prog %0d dmem word %0d", p, i), model_dmem[6'(i)], v);
			end
		end

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
+incdir+sim
hw/mips_isa_pkg.sv
hw/mips_bus_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/dmem_arbiter.sv
hw/apb_debug_port.sv
hw/mips_core_top.sv
sim/tb_mips_core.sv

// ==== Makefile ====
# Verilator flow for the five-stage pipeline testbench
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
SEED      ?= 95849
VFLAGS    ?= --binary --timing --assert

.PHONY: help build test clean

help:
	@echo "make test   build and run the simulation, fails if the log reports a failure"
	@echo "make clean  remove the build directory and the log"
	@echo "overridable: VERILATOR TOP FILELIST BUILD LOG SEED VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

test: build
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
